// ==== include/rvdec_consts.svh ====
`ifndef RVDEC_CONSTS_SVH
`define RVDEC_CONSTS_SVH

// Data path width
`define RVDEC_XLEN 32

// Instruction queue, depth is a power of two
`define RVDEC_QDEPTH 4
`define RVDEC_QAW 2

// Major opcodes, instruction bits 6:2
`define RVDEC_OPC_LOAD   5'b00000
`define RVDEC_OPC_MISC   5'b00011
`define RVDEC_OPC_OPIMM  5'b00100
`define RVDEC_OPC_AUIPC  5'b00101
`define RVDEC_OPC_STORE  5'b01000
`define RVDEC_OPC_OP     5'b01100
`define RVDEC_OPC_LUI    5'b01101
`define RVDEC_OPC_BRANCH 5'b11000
`define RVDEC_OPC_JALR   5'b11001
`define RVDEC_OPC_JAL    5'b11011
`define RVDEC_OPC_SYSTEM 5'b11100

// Supported machine-mode CSRs
`define RVDEC_CSR_MSTATUS  12'h300
`define RVDEC_CSR_MIE      12'h304
`define RVDEC_CSR_MTVEC    12'h305
`define RVDEC_CSR_MSCRATCH 12'h340
`define RVDEC_CSR_MEPC     12'h341
`define RVDEC_CSR_MCAUSE   12'h342
`define RVDEC_CSR_MTVAL    12'h343
`define RVDEC_CSR_MIP      12'h344

`endif

// ==== verilog/rvdec_pkg.sv ====
`include "rvdec_consts.svh"

package rvdec_pkg;

   typedef logic [`RVDEC_XLEN-1:0] instr_t;
   typedef logic [`RVDEC_XLEN-1:0] imm_t;
   typedef logic [4:0]             reg_idx_t;
   typedef logic [2:0]             funct3_t;

   // Operation class of a decoded word
   typedef enum logic [3:0] {
      CLS_ALU     = 4'd0,
      CLS_SHIFT   = 4'd1,
      CLS_SLT     = 4'd2,
      CLS_LOAD    = 4'd3,
      CLS_STORE   = 4'd4,
      CLS_BRANCH  = 4'd5,
      CLS_JAL     = 4'd6,
      CLS_JALR    = 4'd7,
      CLS_LUI     = 4'd8,
      CLS_AUIPC   = 4'd9,
      CLS_CSR     = 4'd10,
      CLS_ECALL   = 4'd11,
      CLS_EBREAK  = 4'd12,
      CLS_MRET    = 4'd13,
      CLS_FENCE   = 4'd14,
      CLS_ILLEGAL = 4'd15
   } op_class_e;

   typedef enum logic [2:0] {
      CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
      CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP
   } csr_sel_e;

   // Fetch side receiver
   typedef enum logic [1:0] {CAP_IDLE, CAP_ACKING, CAP_WAIT_LOW} cap_state_e;

   // Decoder sequencing
   typedef enum logic [1:0] {
      DEC_FETCH, DEC_LATCH, DEC_REQ, DEC_WAIT_ACK_LOW
   } dec_state_e;

endpackage

// ==== verilog/instr_capture.sv ====
`timescale 1ns/1ps

module instr_capture (
   input  logic              clk,
   input  logic              i_rst,
   input  logic              i_instr_req,
   input  rvdec_pkg::instr_t i_instr,
   output logic              o_instr_ack,
   input  logic              i_q_full,
   output logic              o_q_wr,
   output rvdec_pkg::instr_t o_q_wdata
);

   rvdec_pkg::cap_state_e state;
   logic                  ack_q;

   // One push per request, held off while the queue is full
   assign o_q_wr    = (state == rvdec_pkg::CAP_IDLE) && i_instr_req && !i_q_full;
   assign o_q_wdata = i_instr;

   assign o_instr_ack = ack_q;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state <= rvdec_pkg::CAP_IDLE;
         ack_q <= 1'b0;
      end else begin
         case (state)
            rvdec_pkg::CAP_IDLE: begin
               if (o_q_wr) begin
                  state <= rvdec_pkg::CAP_ACKING;
                  ack_q <= 1'b1;
               end
            end
            // Word stored, hold ack until the fetch side lets go
            rvdec_pkg::CAP_ACKING: begin
               if (!i_instr_req) begin
                  state <= rvdec_pkg::CAP_WAIT_LOW;
               end
            end
            // Request seen low, drop ack now
            rvdec_pkg::CAP_WAIT_LOW: begin
               state <= rvdec_pkg::CAP_IDLE;
               ack_q <= 1'b0;
            end
            default: begin
               state <= rvdec_pkg::CAP_IDLE;
               ack_q <= 1'b0;
            end
         endcase
      end
   end

endmodule

// ==== verilog/instr_queue.sv ====
`timescale 1ns/1ps

`include "rvdec_consts.svh"

module instr_queue (
   input  logic              clk,
   input  logic              i_rst,
   input  logic              i_wr,
   input  rvdec_pkg::instr_t i_wdata,
   input  logic              i_rd,
   output rvdec_pkg::instr_t o_rdata,
   output logic              o_full,
   output logic              o_empty
);

   rvdec_pkg::instr_t mem [`RVDEC_QDEPTH];

   logic [`RVDEC_QAW-1:0] wr_ptr;
   logic [`RVDEC_QAW-1:0] rd_ptr;
   logic [`RVDEC_QAW:0]   count;
   logic                  do_wr;
   logic                  do_rd;

   assign o_full  = (count == (`RVDEC_QAW+1)'(`RVDEC_QDEPTH));
   assign o_empty = (count == '0);

   assign do_wr = i_wr && !o_full;
   assign do_rd = i_rd && !o_empty;

   // Show-ahead head word
   assign o_rdata = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= i_wdata;
      end
   end

   // Pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         count <= '0;
      end else begin
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== verilog/instr_decode.sv ====
`timescale 1ns/1ps

`include "rvdec_consts.svh"

module instr_decode (
   input  logic                 clk,
   input  logic                 i_rst,
   input  logic                 i_q_empty,
   output logic                 o_q_rd,
   input  rvdec_pkg::instr_t    i_q_rdata,
   output logic                 o_ctrl_req,
   input  logic                 i_ctrl_ack,
   output rvdec_pkg::op_class_e o_ctrl_class,
   output rvdec_pkg::reg_idx_t  o_ctrl_rd,
   output rvdec_pkg::reg_idx_t  o_ctrl_rs1,
   output rvdec_pkg::reg_idx_t  o_ctrl_rs2,
   output logic                 o_ctrl_rd_we,
   output rvdec_pkg::imm_t      o_ctrl_imm,
   output rvdec_pkg::funct3_t   o_ctrl_funct3,
   output logic                 o_ctrl_alu_sub,
   output logic                 o_ctrl_op_b_imm,
   output logic                 o_ctrl_mem_signed,
   output rvdec_pkg::csr_sel_e  o_ctrl_csr_sel
);

   rvdec_pkg::dec_state_e state;
   rvdec_pkg::instr_t     word_q;

   // Fields of the held word
   logic [4:0]         opcode;
   rvdec_pkg::funct3_t funct3;
   logic               bit30;
   logic [11:0]        sys_imm;
   logic               low_ok;
   logic               is_opimm;

   rvdec_pkg::imm_t imm_i;
   rvdec_pkg::imm_t imm_s;
   rvdec_pkg::imm_t imm_b;
   rvdec_pkg::imm_t imm_u;
   rvdec_pkg::imm_t imm_j;
   rvdec_pkg::imm_t imm;

   rvdec_pkg::op_class_e alu_cls;
   rvdec_pkg::op_class_e cls;
   rvdec_pkg::csr_sel_e  csr_sel;
   logic                 csr_ok;
   logic                 rd_we;
   logic                 alu_sub;
   logic                 op_b_imm;
   logic                 mem_signed;

   assign opcode   = word_q[6:2];
   assign funct3   = word_q[14:12];
   assign bit30    = word_q[30];
   assign sys_imm  = word_q[31:20];
   assign low_ok   = (word_q[1:0] == 2'b11);
   assign is_opimm = (opcode == `RVDEC_OPC_OPIMM);

   // Immediate formats, all sign extended from bit 31
   assign imm_i = {{20{word_q[31]}}, word_q[31:20]};
   assign imm_s = {{20{word_q[31]}}, word_q[31:25], word_q[11:7]};
   assign imm_b = {{19{word_q[31]}}, word_q[31], word_q[7], word_q[30:25], word_q[11:8], 1'b0};
   assign imm_u = {word_q[31:12], 12'b0};
   assign imm_j = {{11{word_q[31]}}, word_q[31], word_q[19:12], word_q[20], word_q[30:21], 1'b0};

   always_comb begin
      csr_ok  = 1'b1;
      csr_sel = rvdec_pkg::CSR_MSTATUS;
      case (sys_imm)
         `RVDEC_CSR_MSTATUS:  csr_sel = rvdec_pkg::CSR_MSTATUS;
         `RVDEC_CSR_MIE:      csr_sel = rvdec_pkg::CSR_MIE;
         `RVDEC_CSR_MTVEC:    csr_sel = rvdec_pkg::CSR_MTVEC;
         `RVDEC_CSR_MSCRATCH: csr_sel = rvdec_pkg::CSR_MSCRATCH;
         `RVDEC_CSR_MEPC:     csr_sel = rvdec_pkg::CSR_MEPC;
         `RVDEC_CSR_MCAUSE:   csr_sel = rvdec_pkg::CSR_MCAUSE;
         `RVDEC_CSR_MTVAL:    csr_sel = rvdec_pkg::CSR_MTVAL;
         `RVDEC_CSR_MIP:      csr_sel = rvdec_pkg::CSR_MIP;
         default:             csr_ok  = 1'b0;
      endcase
   end

   // OP and OPIMM split on funct3
   always_comb begin
      case (funct3)
         3'b001, 3'b101: alu_cls = rvdec_pkg::CLS_SHIFT;
         3'b010, 3'b011: alu_cls = rvdec_pkg::CLS_SLT;
         default:        alu_cls = rvdec_pkg::CLS_ALU;
      endcase
   end

   always_comb begin
      cls = rvdec_pkg::CLS_ILLEGAL;
      if (low_ok) begin
         case (opcode)
            `RVDEC_OPC_OP, `RVDEC_OPC_OPIMM: cls = alu_cls;
            `RVDEC_OPC_LOAD:   cls = rvdec_pkg::CLS_LOAD;
            `RVDEC_OPC_STORE:  cls = rvdec_pkg::CLS_STORE;
            `RVDEC_OPC_BRANCH: cls = rvdec_pkg::CLS_BRANCH;
            `RVDEC_OPC_JAL:    cls = rvdec_pkg::CLS_JAL;
            `RVDEC_OPC_JALR:   cls = rvdec_pkg::CLS_JALR;
            `RVDEC_OPC_LUI:    cls = rvdec_pkg::CLS_LUI;
            `RVDEC_OPC_AUIPC:  cls = rvdec_pkg::CLS_AUIPC;
            `RVDEC_OPC_MISC:   cls = rvdec_pkg::CLS_FENCE;
            `RVDEC_OPC_SYSTEM: begin
               if (funct3 == 3'b000) begin
                  case (sys_imm)
                     12'h000: cls = rvdec_pkg::CLS_ECALL;
                     12'h001: cls = rvdec_pkg::CLS_EBREAK;
                     12'h302: cls = rvdec_pkg::CLS_MRET;
                     default: cls = rvdec_pkg::CLS_ILLEGAL;
                  endcase
               end else if (csr_ok) begin
                  cls = rvdec_pkg::CLS_CSR;
               end
            end
            default: cls = rvdec_pkg::CLS_ILLEGAL;
         endcase
      end
   end

   // Immediate picked by class so illegal words give zero
   always_comb begin
      case (cls)
         rvdec_pkg::CLS_ALU, rvdec_pkg::CLS_SHIFT, rvdec_pkg::CLS_SLT:
            imm = is_opimm ? imm_i : '0;
         rvdec_pkg::CLS_LOAD, rvdec_pkg::CLS_JALR, rvdec_pkg::CLS_CSR,
         rvdec_pkg::CLS_ECALL, rvdec_pkg::CLS_EBREAK, rvdec_pkg::CLS_MRET:
            imm = imm_i;
         rvdec_pkg::CLS_STORE:  imm = imm_s;
         rvdec_pkg::CLS_BRANCH: imm = imm_b;
         rvdec_pkg::CLS_LUI, rvdec_pkg::CLS_AUIPC: imm = imm_u;
         rvdec_pkg::CLS_JAL:    imm = imm_j;
         default:               imm = '0;
      endcase
   end

   assign rd_we = cls inside {rvdec_pkg::CLS_ALU, rvdec_pkg::CLS_SHIFT, rvdec_pkg::CLS_SLT,
                              rvdec_pkg::CLS_LOAD, rvdec_pkg::CLS_JAL, rvdec_pkg::CLS_JALR,
                              rvdec_pkg::CLS_LUI, rvdec_pkg::CLS_AUIPC, rvdec_pkg::CLS_CSR};

   // SUB, compares and arithmetic right shifts
   assign alu_sub = (cls == rvdec_pkg::CLS_ALU && !is_opimm && funct3 == 3'b000 && bit30) ||
                    (cls == rvdec_pkg::CLS_SLT) || (cls == rvdec_pkg::CLS_BRANCH) ||
                    (cls == rvdec_pkg::CLS_SHIFT && funct3[2] && bit30);

   assign op_b_imm = (cls inside {rvdec_pkg::CLS_LOAD, rvdec_pkg::CLS_STORE,
                                  rvdec_pkg::CLS_JALR, rvdec_pkg::CLS_LUI,
                                  rvdec_pkg::CLS_AUIPC}) ||
                     (is_opimm && cls inside {rvdec_pkg::CLS_ALU, rvdec_pkg::CLS_SHIFT,
                                              rvdec_pkg::CLS_SLT});

   assign mem_signed = (cls == rvdec_pkg::CLS_LOAD) && !funct3[2];

   assign o_q_rd = (state == rvdec_pkg::DEC_FETCH) && !i_q_empty;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state      <= rvdec_pkg::DEC_FETCH;
         o_ctrl_req <= 1'b0;
      end else begin
         case (state)
            rvdec_pkg::DEC_FETCH: begin
               if (!i_q_empty) begin
                  state <= rvdec_pkg::DEC_LATCH;
               end
            end
            rvdec_pkg::DEC_LATCH: begin
               state      <= rvdec_pkg::DEC_REQ;
               o_ctrl_req <= 1'b1;
            end
            rvdec_pkg::DEC_REQ: begin
               if (i_ctrl_ack) begin
                  state      <= rvdec_pkg::DEC_WAIT_ACK_LOW;
                  o_ctrl_req <= 1'b0;
               end
            end
            rvdec_pkg::DEC_WAIT_ACK_LOW: begin
               if (!i_ctrl_ack) begin
                  state <= rvdec_pkg::DEC_FETCH;
               end
            end
            default: begin
               state      <= rvdec_pkg::DEC_FETCH;
               o_ctrl_req <= 1'b0;
            end
         endcase
      end
   end

   // Word and bundle registers, bundle frozen until the next LATCH
   always_ff @(posedge clk) begin
      if (o_q_rd) begin
         word_q <= i_q_rdata;
      end
      if (state == rvdec_pkg::DEC_LATCH) begin
         o_ctrl_class      <= cls;
         o_ctrl_rd         <= word_q[11:7];
         o_ctrl_rs1        <= word_q[19:15];
         o_ctrl_rs2        <= word_q[24:20];
         o_ctrl_rd_we      <= rd_we;
         o_ctrl_imm        <= imm;
         o_ctrl_funct3     <= funct3;
         o_ctrl_alu_sub    <= alu_sub;
         o_ctrl_op_b_imm   <= op_b_imm;
         o_ctrl_mem_signed <= mem_signed;
         o_ctrl_csr_sel    <= csr_sel;
      end
   end

endmodule

// ==== verilog/rvdec_top.sv ====
`timescale 1ns/1ps

module rvdec_top (
   input  logic                 clk,
   input  logic                 i_rst,
   input  logic                 i_instr_req,
   input  rvdec_pkg::instr_t    i_instr,
   output logic                 o_instr_ack,
   output logic                 o_ctrl_req,
   input  logic                 i_ctrl_ack,
   output rvdec_pkg::op_class_e o_ctrl_class,
   output rvdec_pkg::reg_idx_t  o_ctrl_rd,
   output rvdec_pkg::reg_idx_t  o_ctrl_rs1,
   output rvdec_pkg::reg_idx_t  o_ctrl_rs2,
   output logic                 o_ctrl_rd_we,
   output rvdec_pkg::imm_t      o_ctrl_imm,
   output rvdec_pkg::funct3_t   o_ctrl_funct3,
   output logic                 o_ctrl_alu_sub,
   output logic                 o_ctrl_op_b_imm,
   output logic                 o_ctrl_mem_signed,
   output rvdec_pkg::csr_sel_e  o_ctrl_csr_sel
);

   // Queue side signals
   logic              q_wr;
   rvdec_pkg::instr_t q_wdata;
   logic              q_full;
   logic              q_rd;
   rvdec_pkg::instr_t q_rdata;
   logic              q_empty;

   instr_capture i_instr_capture (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_instr_req (i_instr_req),
      .i_instr     (i_instr),
      .o_instr_ack (o_instr_ack),
      .i_q_full    (q_full),
      .o_q_wr      (q_wr),
      .o_q_wdata   (q_wdata)
   );

   instr_queue i_instr_queue (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_wr    (q_wr),
      .i_wdata (q_wdata),
      .i_rd    (q_rd),
      .o_rdata (q_rdata),
      .o_full  (q_full),
      .o_empty (q_empty)
   );

   instr_decode i_instr_decode (
      .clk               (clk),
      .i_rst             (i_rst),
      .i_q_empty         (q_empty),
      .o_q_rd            (q_rd),
      .i_q_rdata         (q_rdata),
      .o_ctrl_req        (o_ctrl_req),
      .i_ctrl_ack        (i_ctrl_ack),
      .o_ctrl_class      (o_ctrl_class),
      .o_ctrl_rd         (o_ctrl_rd),
      .o_ctrl_rs1        (o_ctrl_rs1),
      .o_ctrl_rs2        (o_ctrl_rs2),
      .o_ctrl_rd_we      (o_ctrl_rd_we),
      .o_ctrl_imm        (o_ctrl_imm),
      .o_ctrl_funct3     (o_ctrl_funct3),
      .o_ctrl_alu_sub    (o_ctrl_alu_sub),
      .o_ctrl_op_b_imm   (o_ctrl_op_b_imm),
      .o_ctrl_mem_signed (o_ctrl_mem_signed),
      .o_ctrl_csr_sel    (o_ctrl_csr_sel)
   );

endmodule

// ==== sim/tb_rvdec.sv ====
`timescale 1ns/1ps

`include "rvdec_consts.svh"

module tb_rvdec;

   localparam int TIMEOUT_CYCLES = 600 * 60;

   localparam logic [4:0] OPCODES [11] = '{
      `RVDEC_OPC_LOAD, `RVDEC_OPC_MISC, `RVDEC_OPC_OPIMM, `RVDEC_OPC_AUIPC,
      `RVDEC_OPC_STORE, `RVDEC_OPC_OP, `RVDEC_OPC_LUI, `RVDEC_OPC_BRANCH,
      `RVDEC_OPC_JALR, `RVDEC_OPC_JAL, `RVDEC_OPC_SYSTEM
   };

   // Indexed by the csr_sel_e encoding
   localparam logic [11:0] CSR_ADDRS [8] = '{
      `RVDEC_CSR_MSTATUS, `RVDEC_CSR_MIE, `RVDEC_CSR_MTVEC, `RVDEC_CSR_MSCRATCH,
      `RVDEC_CSR_MEPC, `RVDEC_CSR_MCAUSE, `RVDEC_CSR_MTVAL, `RVDEC_CSR_MIP
   };

   logic                 clk;
   logic                 i_rst;
   logic                 i_instr_req;
   rvdec_pkg::instr_t    i_instr;
   logic                 o_instr_ack;
   logic                 o_ctrl_req;
   logic                 i_ctrl_ack;
   rvdec_pkg::op_class_e o_ctrl_class;
   rvdec_pkg::reg_idx_t  o_ctrl_rd;
   rvdec_pkg::reg_idx_t  o_ctrl_rs1;
   rvdec_pkg::reg_idx_t  o_ctrl_rs2;
   logic                 o_ctrl_rd_we;
   rvdec_pkg::imm_t      o_ctrl_imm;
   rvdec_pkg::funct3_t   o_ctrl_funct3;
   logic                 o_ctrl_alu_sub;
   logic                 o_ctrl_op_b_imm;
   logic                 o_ctrl_mem_signed;
   rvdec_pkg::csr_sel_e  o_ctrl_csr_sel;
   logic [60:0]          bundle;

   // Scoreboard of words offered but not yet seen as a bundle
   logic [31:0] sent_q [$];
   string       name_q [$];
   int          sent_total = 0;
   int          recv_count = 0;
   int          cycles = 0;
   logic        req_prev;
   logic        wait_prev;
   int          prev_outstanding;

   rvdec_top i_rvdec_top (.*);

   assign bundle = {o_ctrl_class, o_ctrl_rd, o_ctrl_rs1, o_ctrl_rs2, o_ctrl_rd_we, o_ctrl_imm,
                    o_ctrl_funct3, o_ctrl_alu_sub, o_ctrl_op_b_imm, o_ctrl_mem_signed,
                    o_ctrl_csr_sel};

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   task automatic check_field(input string test, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
      assert (actual === expected) else abort_run($sformatf(
         "ERROR test=%s field=%s expected=%h actual=%h", test, field, expected, actual));
   endtask

   function automatic void csr_lookup(input logic [11:0] addr, output logic hit,
                                      output rvdec_pkg::csr_sel_e sel);
      int i;
      hit = 1'b0;
      sel = rvdec_pkg::CSR_MSTATUS;
      for (i = 0; i < 8; i++) begin
         if (CSR_ADDRS[i] == addr) begin
            hit = 1'b1;
            sel = rvdec_pkg::csr_sel_e'(i);
         end
      end
   endfunction

   function automatic void ref_decode(input logic [31:0] w, output rvdec_pkg::op_class_e cls,
                                      output logic [31:0] imm, output logic we,
                                      output logic sub, output logic bimm,
                                      output logic msigned, output rvdec_pkg::csr_sel_e csr);
      logic [4:0]  opc;
      logic [2:0]  f3;
      logic [11:0] sys;
      logic        hit;
      opc = w[6:2];
      f3  = w[14:12];
      sys = w[31:20];
      csr_lookup(sys, hit, csr);
      cls = rvdec_pkg::CLS_ILLEGAL;
      imm = '0;
      if (w[1:0] == 2'b11) begin
         case (opc)
            `RVDEC_OPC_OP, `RVDEC_OPC_OPIMM: begin
               if (f3 == 3'b001 || f3 == 3'b101) cls = rvdec_pkg::CLS_SHIFT;
               else if (f3 == 3'b010 || f3 == 3'b011) cls = rvdec_pkg::CLS_SLT;
               else cls = rvdec_pkg::CLS_ALU;
            end
            `RVDEC_OPC_LOAD:   cls = rvdec_pkg::CLS_LOAD;
            `RVDEC_OPC_STORE:  cls = rvdec_pkg::CLS_STORE;
            `RVDEC_OPC_BRANCH: cls = rvdec_pkg::CLS_BRANCH;
            `RVDEC_OPC_JAL:    cls = rvdec_pkg::CLS_JAL;
            `RVDEC_OPC_JALR:   cls = rvdec_pkg::CLS_JALR;
            `RVDEC_OPC_LUI:    cls = rvdec_pkg::CLS_LUI;
            `RVDEC_OPC_AUIPC:  cls = rvdec_pkg::CLS_AUIPC;
            `RVDEC_OPC_MISC:   cls = rvdec_pkg::CLS_FENCE;
            `RVDEC_OPC_SYSTEM: begin
               if (f3 != 3'b000) cls = hit ? rvdec_pkg::CLS_CSR : rvdec_pkg::CLS_ILLEGAL;
               else if (sys == 12'h000) cls = rvdec_pkg::CLS_ECALL;
               else if (sys == 12'h001) cls = rvdec_pkg::CLS_EBREAK;
               else if (sys == 12'h302) cls = rvdec_pkg::CLS_MRET;
            end
            default: cls = rvdec_pkg::CLS_ILLEGAL;
         endcase
         // Illegal words carry no immediate
         if (cls != rvdec_pkg::CLS_ILLEGAL) begin
            case (opc)
               `RVDEC_OPC_OPIMM, `RVDEC_OPC_LOAD, `RVDEC_OPC_JALR, `RVDEC_OPC_SYSTEM:
                  imm = 32'($signed(sys));
               `RVDEC_OPC_STORE:  imm = 32'($signed({w[31:25], w[11:7]}));
               `RVDEC_OPC_BRANCH: imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
               `RVDEC_OPC_LUI, `RVDEC_OPC_AUIPC: imm = {w[31:12], 12'h000};
               `RVDEC_OPC_JAL: imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
               default: imm = '0;
            endcase
         end
      end
      we = cls inside {rvdec_pkg::CLS_ALU, rvdec_pkg::CLS_SHIFT, rvdec_pkg::CLS_SLT,
                       rvdec_pkg::CLS_LOAD, rvdec_pkg::CLS_JAL, rvdec_pkg::CLS_JALR,
                       rvdec_pkg::CLS_LUI, rvdec_pkg::CLS_AUIPC, rvdec_pkg::CLS_CSR};
      sub = (cls == rvdec_pkg::CLS_ALU && opc == `RVDEC_OPC_OP && f3 == 3'b000 && w[30]) ||
            cls == rvdec_pkg::CLS_SLT || cls == rvdec_pkg::CLS_BRANCH ||
            (cls == rvdec_pkg::CLS_SHIFT && f3 == 3'b101 && w[30]);
      bimm = (w[1:0] == 2'b11) && (opc inside {`RVDEC_OPC_OPIMM, `RVDEC_OPC_LOAD,
             `RVDEC_OPC_STORE, `RVDEC_OPC_JALR, `RVDEC_OPC_LUI, `RVDEC_OPC_AUIPC});
      msigned = (cls == rvdec_pkg::CLS_LOAD) && !f3[2];
   endfunction

   function automatic logic [31:0] rand_word(input logic [4:0] opc);
      logic [31:0] r;
      r = $urandom();
      return {r[31:7], opc, 2'b11};
   endfunction

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] opc);
      logic [31:0] r;
      r = $urandom();
      return {f7, r[24:15], f3, r[11:7], opc, 2'b11};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [4:0] opc);
      logic [31:0] r;
      r = $urandom();
      return {imm, r[19:15], f3, r[11:7], opc, 2'b11};
   endfunction

   // Fetch side of the four-phase input handshake
   task automatic send_word(input logic [31:0] w, input string name);
      repeat ($urandom() % 13) @(negedge clk);
      sent_q.push_back(w);
      name_q.push_back(name);
      sent_total++;
      i_instr     = w;
      i_instr_req = 1'b1;
      @(negedge clk);
      while (!o_instr_ack) @(negedge clk);
      i_instr_req = 1'b0;
      @(negedge clk);
      while (o_instr_ack) @(negedge clk);
   endtask

   // Ack may linger after the request drops
   task automatic respond_once();
      while (!o_ctrl_req) @(negedge clk);
      repeat ($urandom() % 13) @(negedge clk);
      i_ctrl_ack = 1'b1;
      while (o_ctrl_req) @(negedge clk);
      repeat ($urandom() % 13) @(negedge clk);
      i_ctrl_ack = 1'b0;
      @(negedge clk);
   endtask

   task automatic wait_drain();
      while (sent_q.size() != 0) @(negedge clk);
   endtask

   task automatic check_bundle();
      logic [31:0]          w;
      string                name;
      rvdec_pkg::op_class_e cls;
      logic [31:0]          imm;
      logic                 we;
      logic                 sub;
      logic                 bimm;
      logic                 msigned;
      rvdec_pkg::csr_sel_e  csr;
      if (sent_q.size() == 0) begin
         abort_run("Control request raised with no instruction outstanding");
      end else begin
         w    = sent_q.pop_front();
         name = name_q.pop_front();
         ref_decode(w, cls, imm, we, sub, bimm, msigned, csr);
         check_field(name, "class", 32'(cls), 32'(o_ctrl_class));
         check_field(name, "rd", 32'(w[11:7]), 32'(o_ctrl_rd));
         check_field(name, "rs1", 32'(w[19:15]), 32'(o_ctrl_rs1));
         check_field(name, "rs2", 32'(w[24:20]), 32'(o_ctrl_rs2));
         check_field(name, "rd_we", 32'(we), 32'(o_ctrl_rd_we));
         check_field(name, "imm", imm, o_ctrl_imm);
         check_field(name, "funct3", 32'(w[14:12]), 32'(o_ctrl_funct3));
         check_field(name, "alu_sub", 32'(sub), 32'(o_ctrl_alu_sub));
         check_field(name, "op_b_imm", 32'(bimm), 32'(o_ctrl_op_b_imm));
         check_field(name, "mem_signed", 32'(msigned), 32'(o_ctrl_mem_signed));
         if (cls == rvdec_pkg::CLS_CSR) begin
            check_field(name, "csr_sel", 32'(csr), 32'(o_ctrl_csr_sel));
         end
         recv_count++;
      end
   endtask

   // Sampled on the rising edge while inputs move on the falling edge
   always @(posedge clk) begin
      if (i_rst) begin
         req_prev  = 1'b0;
         wait_prev = 1'b0;
      end else begin
         // A request still unacked one cycle on means the queue was full
         if (wait_prev && i_instr_req && !o_instr_ack) begin
            assert (prev_outstanding >= 5) else abort_run($sformatf(
               "Fetch stalled with only %0d words outstanding", prev_outstanding));
         end
         wait_prev        = i_instr_req && !o_instr_ack;
         prev_outstanding = sent_q.size();
         if (o_ctrl_req && !req_prev) begin
            check_bundle();
         end
         req_prev = o_ctrl_req;
      end
   end

   ack_needs_req: assert property (@(posedge clk) disable iff (i_rst)
      $rose(o_instr_ack) |-> $past(i_instr_req))
      else abort_run("Fetch ack rose without a pending request");

   req_falls_after_ack: assert property (@(posedge clk) disable iff (i_rst)
      $fell(o_ctrl_req) |-> $past(i_ctrl_ack))
      else abort_run("Control request dropped before the consumer acked");

   req_rises_with_ack_low: assert property (@(posedge clk) disable iff (i_rst)
      $rose(o_ctrl_req) |-> !$past(i_ctrl_ack))
      else abort_run("Control request raised while ack was still high");

   bundle_stable: assert property (@(posedge clk) disable iff (i_rst)
      o_ctrl_req && $past(o_ctrl_req) |-> $stable(bundle))
      else abort_run("Control bundle changed while the request was high");

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         abort_run($sformatf("Timeout after %0d cycles", cycles));
      end
   end

   initial begin
      @(negedge i_rst);
      @(negedge clk);
      forever respond_once();
   end

   initial begin
      int          k;
      int          f;
      int          b;
      logic [6:0]  f7;
      logic [31:0] r;
      logic [31:0] w;
      void'($urandom(84497));
      i_rst       = 1'b1;
      i_instr_req = 1'b0;
      i_instr     = '0;
      i_ctrl_ack  = 1'b0;
      // Reset checks start after the first rising edge
      @(posedge clk);
      repeat (16) begin
         @(negedge clk);
         assert (o_instr_ack === 1'b0 && o_ctrl_req === 1'b0)
            else abort_run("Handshake outputs not low during reset");
      end
      i_rst = 1'b0;
      @(negedge clk);
      assert (o_instr_ack === 1'b0 && o_ctrl_req === 1'b0)
         else abort_run("Handshake outputs not low after reset");

      for (k = 0; k < 11; k++) send_word(rand_word(OPCODES[k]), "class_decode");
      for (f = 0; f < 8; f++) begin
         r = $urandom();
         send_word(enc_r(7'h00, f[2:0], `RVDEC_OPC_OP), "class_decode");
         send_word(enc_i(r[11:0], f[2:0], `RVDEC_OPC_OPIMM), "class_decode");
      end
      send_word(enc_i(12'h010, 3'b000, `RVDEC_OPC_LOAD), "class_decode");
      send_word(enc_i(12'hff0, 3'b100, `RVDEC_OPC_LOAD), "class_decode");
      send_word(enc_r(7'h00, 3'b000, `RVDEC_OPC_OP) & 32'hffff_fffe, "class_decode");
      send_word(rand_word(5'b11111), "class_decode");
      send_word(rand_word(5'b01010), "class_decode");
      wait_drain();

      // Bit 31 alternates so both signs show up
      for (k = 0; k < 20; k++) begin
         for (f = 0; f < 5; f++) begin
            w     = rand_word(f == 0 ? `RVDEC_OPC_OPIMM : f == 1 ? `RVDEC_OPC_STORE :
                              f == 2 ? `RVDEC_OPC_BRANCH : f == 3 ? `RVDEC_OPC_LUI :
                              `RVDEC_OPC_JAL);
            w[31] = k[0];
            send_word(w, "immediates");
         end
      end
      wait_drain();

      for (b = 0; b < 2; b++) begin
         f7 = (b != 0) ? 7'h20 : 7'h00;
         send_word(enc_r(f7, 3'b000, `RVDEC_OPC_OP), "alu_qualifiers");
         send_word(enc_r(f7, 3'b101, `RVDEC_OPC_OP), "alu_qualifiers");
         send_word(enc_i({f7, 5'd3}, 3'b101, `RVDEC_OPC_OPIMM), "alu_qualifiers");
         send_word(enc_i({f7, 5'd9}, 3'b000, `RVDEC_OPC_OPIMM), "alu_qualifiers");
         send_word(enc_r(f7, 3'b010, `RVDEC_OPC_OP), "alu_qualifiers");
         send_word(enc_r(f7, 3'b011, `RVDEC_OPC_OP), "alu_qualifiers");
      end
      for (f = 0; f < 8; f++) begin
         r = $urandom();
         send_word(enc_r(r[31:25], f[2:0], `RVDEC_OPC_BRANCH), "alu_qualifiers");
      end
      wait_drain();

      send_word(enc_i(12'h000, 3'b000, `RVDEC_OPC_SYSTEM), "system_csr");
      send_word(enc_i(12'h001, 3'b000, `RVDEC_OPC_SYSTEM), "system_csr");
      send_word(enc_i(12'h302, 3'b000, `RVDEC_OPC_SYSTEM), "system_csr");
      send_word(enc_i(12'h105, 3'b000, `RVDEC_OPC_SYSTEM), "system_csr");
      for (k = 0; k < 8; k++) begin
         for (f = 1; f < 8; f++) begin
            send_word(enc_i(CSR_ADDRS[k], f[2:0], `RVDEC_OPC_SYSTEM), "system_csr");
         end
      end
      send_word(enc_i(12'h7c0, 3'b001, `RVDEC_OPC_SYSTEM), "system_csr");
      wait_drain();

      // Mostly legal words with about one in eight having broken low bits
      for (k = 0; k < 400; k++) begin
         r = $urandom();
         w = rand_word(OPCODES[r % 11]);
         if (r[31:29] == 3'b000) w[1:0] = r[5:4];
         send_word(w, "order_backpressure");
      end
      wait_drain();

      if (recv_count == sent_total) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         abort_run($sformatf("Sent %0d words but received %0d bundles",
                             sent_total, recv_count));
      end
   end

endmodule

// ==== vlog.f ====
+incdir+include
verilog/rvdec_pkg.sv
verilog/instr_capture.sv
verilog/instr_queue.sv
verilog/instr_decode.sv
verilog/rvdec_top.sv
sim/tb_rvdec.sv
